// File: src/hru_pkg.sv
// Shared types for the hazard resolution unit, imported by the RTL blocks that use them
package hru_pkg;

  // Data-memory address width
  localparam int unsigned XLEN = 32;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // ====================
  // Stage structs
  // ====================

  // Early source indices of the instruction sitting in PD
  typedef struct packed {
    reg_idx_t rs1_early;
    reg_idx_t rs2_early;
  } pd_to_id_t;

  // Decoded class and destination of the instruction in EX
  typedef struct packed {
    logic     is_load;
    logic     is_multiply;
    logic     is_divide;
    logic     is_csr;
    reg_idx_t dest_reg;
  } id_to_ex_t;

  // Combinational EX results
  // The multiplier raises mul_completing_next_cycle one cycle before its result is valid
  typedef struct packed {
    logic branch_taken;
    logic mul_completing_next_cycle;
    logic div_busy;
  } ex_comb_t;

  // The instruction in MA, with the data address it accesses
  typedef struct packed {
    logic            is_load;
    logic [XLEN-1:0] data_addr;
  } ex_to_ma_t;

  // Cache status, both fields come from cache flops
  typedef struct packed {
    logic cache_hit_on_load_reg;
    logic cache_reset_in_progress;
  } cache_status_t;

  // ====================
  // Control output
  // ====================

  // Control bundle broadcast to every pipeline stage
  typedef struct packed {
    logic reset;
    logic stall;
    logic flush;
    logic stall_registered;
    logic stall_for_load_use_hazard;
    logic load_use_hazard_detected;
    logic trap_taken_registered;
    logic mret_taken_registered;
  } pipeline_ctrl_t;

  // Progress of the two-cycle MMIO load bubble
  typedef enum logic [1:0] {
    MMIO_IDLE,
    MMIO_HOLD,
    MMIO_RELEASE
  } mmio_phase_e;

endpackage : hru_pkg

// File: src/load_use_detector.sv
// Load-use hazard detector, registers the potential hazard and decides the stall one cycle later
module load_use_detector
  import hru_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_pipeline_reset,
  input  logic      i_pipeline_stall,
  input  logic      i_pipeline_flush,
  input  pd_to_id_t i_from_pd_to_id,
  input  id_to_ex_t i_from_id_to_ex,
  input  ex_to_ma_t i_from_ex_to_ma,
  input  logic      i_cache_hit_on_load_reg,
  input  logic      i_mul_div_stall,
  output logic      o_load_use_hazard_detected,
  output logic      o_stall_for_load_use_hazard
);

  logic dest_matches_source;
  logic potential_hazard;
  logic potential_hazard_reg;
  logic back_to_back_reg;

  // ====================
  // Fast path
  // ====================

  // Only registered pipeline fields feed this compare, so it settles early in the cycle
  assign dest_matches_source = (i_from_id_to_ex.dest_reg == i_from_pd_to_id.rs1_early) ||
                               (i_from_id_to_ex.dest_reg == i_from_pd_to_id.rs2_early);

  // Writes to x0 are discarded and can never create a dependency
  assign potential_hazard = i_from_id_to_ex.is_load &&
                            (i_from_id_to_ex.dest_reg != '0) &&
                            dest_matches_source;

  // The slow cache-hit flag arrives already registered, so both halves meet here one cycle later
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || i_pipeline_flush) begin
      potential_hazard_reg <= 1'b0;
    end else if (!i_pipeline_stall) begin
      potential_hazard_reg <= potential_hazard;
    end
  end

  // ====================
  // Decision
  // ====================

  // A cache hit means the load data can be forwarded without waiting
  assign o_load_use_hazard_detected = potential_hazard_reg && !back_to_back_reg &&
                                      !i_cache_hit_on_load_reg;

  // Multiply and divide stalls take precedence and hide the load-use bubble
  assign o_stall_for_load_use_hazard = o_load_use_hazard_detected && !i_mul_div_stall;

  // Marks that the load now in MA already took its bubble
  // Under some other stall the mark survives only while a load still occupies MA
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      back_to_back_reg <= 1'b0;
    end else if (o_stall_for_load_use_hazard) begin
      back_to_back_reg <= 1'b1;
    end else if (!i_pipeline_stall) begin
      back_to_back_reg <= 1'b0;
    end else begin
      back_to_back_reg <= back_to_back_reg && i_from_ex_to_ma.is_load;
    end
  end

  // The bubble is a single cycle, a held hazard must not stretch it
  a_load_use_single_cycle : assert property (
    @(posedge i_clk) disable iff (i_pipeline_reset)
    o_stall_for_load_use_hazard |=> !o_stall_for_load_use_hazard
  ) else $error("load-use stall held for two cycles");

endmodule : load_use_detector

// File: src/mmio_read_sequencer.sv
// Holds an MMIO load in MA for two cycles and pulses its read side effect once
module mmio_read_sequencer
  import hru_pkg::*;
#(
  parameter logic [XLEN-1:0] MMIO_ADDR       = 32'h4000_0000,
  parameter logic [XLEN-1:0] MMIO_SIZE_BYTES = 32'h28
) (
  input  logic      i_clk,
  input  logic      i_pipeline_reset,
  input  logic      i_pipeline_stall,
  input  logic      i_pipeline_flush,
  input  ex_to_ma_t i_from_ex_to_ma,
  output logic      o_mmio_load_stall,
  output logic      o_mmio_read_pulse
);

  // One bit wider so the window end cannot wrap at the top of the address space
  localparam logic [XLEN:0] MMIO_END = MMIO_ADDR + MMIO_SIZE_BYTES;

  logic        mmio_load_in_ma;
  mmio_phase_e phase;

  assign mmio_load_in_ma = i_from_ex_to_ma.is_load &&
                           (i_from_ex_to_ma.data_addr >= MMIO_ADDR) &&
                           ({1'b0, i_from_ex_to_ma.data_addr} < MMIO_END);

  // Stall in IDLE and HOLD, then let the load go in RELEASE
  assign o_mmio_load_stall = mmio_load_in_ma && (phase != MMIO_RELEASE);

  // The peripheral pops its FIFO on this pulse, so it fires on first sight of the load only
  assign o_mmio_read_pulse = mmio_load_in_ma && (phase == MMIO_IDLE);

  // A flush or an advancing pipeline sends the machine back to idle
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      phase <= MMIO_IDLE;
    end else if (i_pipeline_flush || !i_pipeline_stall) begin
      phase <= MMIO_IDLE;
    end else if (mmio_load_in_ma) begin
      case (phase)
        MMIO_IDLE: phase <= MMIO_HOLD;
        MMIO_HOLD: phase <= MMIO_RELEASE;
        default:   phase <= MMIO_RELEASE;
      endcase
    end
  end

  // Two held MMIO stall cycles are always followed by the release of the load
  a_release_ends_stall : assert property (
    @(posedge i_clk) disable iff (i_pipeline_reset)
    $past(o_mmio_load_stall && i_pipeline_stall && !i_pipeline_reset, 2) &&
      $past(o_mmio_load_stall && i_pipeline_stall && !i_pipeline_reset) |->
      !o_mmio_load_stall
  ) else $error("MMIO bubble longer than two cycles");

  // A trap flush may restart the sequence, otherwise the pulse is strictly single
  a_pulse_single : assert property (
    @(posedge i_clk) disable iff (i_pipeline_reset || i_pipeline_flush)
    o_mmio_read_pulse |=> !o_mmio_read_pulse
  ) else $error("MMIO read pulse high two cycles running");

endmodule : mmio_read_sequencer

// File: src/stall_arbiter.sv
// Stall arbiter, builds the multiply, divide and CSR stalls and merges every stall source
module stall_arbiter
  import hru_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_pipeline_reset,
  input  id_to_ex_t i_from_id_to_ex,
  input  ex_comb_t  i_from_ex_comb,
  input  logic      i_load_use_stall,
  input  logic      i_mmio_load_stall,
  input  logic      i_stall_for_wfi,
  input  logic      i_trap_taken,
  input  logic      i_mret_taken,
  output logic      o_mul_div_stall,
  output logic      o_pipeline_stall
);

  logic multiply_completing_reg;
  logic csr_read_waiting;
  logic stall_for_csr_read;
  logic stall_sources;

  // ====================
  // Multiply and divide
  // ====================

  // Registering the prediction lines it up with the cycle the product becomes valid,
  // and keeps the multiplier off the stall path
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      multiply_completing_reg <= 1'b0;
    end else begin
      multiply_completing_reg <= i_from_ex_comb.mul_completing_next_cycle;
    end
  end

  // The divider reports busy for its whole iteration count
  assign o_mul_div_stall = (i_from_id_to_ex.is_multiply && !multiply_completing_reg) ||
                           (i_from_id_to_ex.is_divide && i_from_ex_comb.div_busy);

  // ====================
  // CSR read
  // ====================

  // CSR read data is registered in the CSR file, so the first EX cycle waits for it
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      csr_read_waiting <= 1'b0;
    end else begin
      csr_read_waiting <= i_from_id_to_ex.is_csr && !csr_read_waiting;
    end
  end

  assign stall_for_csr_read = i_from_id_to_ex.is_csr && !csr_read_waiting;

  // ====================
  // Merge
  // ====================

  assign stall_sources = |{o_mul_div_stall,
                           i_load_use_stall,
                           stall_for_csr_read,
                           i_mmio_load_stall,
                           i_stall_for_wfi};

  // Trap and MRET redirect fetch, so whatever was stalling is flushed anyway
  // This is also how an interrupt breaks a WFI stall
  assign o_pipeline_stall = stall_sources && !i_trap_taken && !i_mret_taken;

  a_trap_overrides_stall : assert property (
    @(posedge i_clk) disable iff (i_pipeline_reset)
    (i_trap_taken || i_mret_taken) && stall_sources |-> !o_pipeline_stall
  ) else $error("stall held through a trap or MRET");

endmodule : stall_arbiter

// File: src/flush_controller.sv
// Flush controller, stretches branch, trap and MRET events into a two-cycle flush
module flush_controller (
  input  logic i_clk,
  input  logic i_pipeline_reset,
  input  logic i_pipeline_stall,
  input  logic i_branch_taken,
  input  logic i_trap_taken,
  input  logic i_mret_taken,
  output logic o_pipeline_flush,
  output logic o_stall_registered,
  output logic o_trap_taken_registered,
  output logic o_mret_taken_registered
);

  logic branch_taken_registered;
  logic any_event;

  // ====================
  // Event registers
  // ====================

  // A stall clears the copies, otherwise a stale event would flush
  // the correct instruction arriving once the stall ends
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || i_pipeline_stall) begin
      branch_taken_registered <= 1'b0;
      o_trap_taken_registered <= 1'b0;
      o_mret_taken_registered <= 1'b0;
    end else begin
      branch_taken_registered <= i_branch_taken;
      o_trap_taken_registered <= i_trap_taken;
      o_mret_taken_registered <= i_mret_taken;
    end
  end

  // ====================
  // Flush
  // ====================

  // Both PD and ID hold wrong-path instructions, hence the event cycle plus one more
  assign any_event = i_branch_taken || branch_taken_registered ||
                     i_trap_taken || o_trap_taken_registered ||
                     i_mret_taken || o_mret_taken_registered;

  assign o_pipeline_flush = any_event && !i_pipeline_stall;

  // Stall history for the fetch and memory stages
  // Cleared by flush because after a redirect the live values are the right ones
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || o_pipeline_flush) begin
      o_stall_registered <= 1'b0;
    end else begin
      o_stall_registered <= i_pipeline_stall;
    end
  end

  a_stall_flush_exclusive : assert property (
    @(posedge i_clk) disable iff (i_pipeline_reset)
    !(o_pipeline_flush && i_pipeline_stall)
  ) else $error("stall and flush asserted together");

  // An unstalled event keeps flushing one more cycle unless that cycle stalls
  a_flush_two_cycles : assert property (
    @(posedge i_clk) disable iff (i_pipeline_reset)
    (i_branch_taken || i_trap_taken || i_mret_taken) && !i_pipeline_stall |=>
      o_pipeline_flush || i_pipeline_stall
  ) else $error("second flush cycle missing");

endmodule : flush_controller

// File: src/retire_tracker.sv
// Stage-fill tracker, raises the instruction-valid and PC-valid strobes once the pipeline fills
module retire_tracker #(
  parameter int unsigned NUM_PIPELINE_STAGES   = 6,
  parameter int unsigned PC_VALID_STAGE_OFFSET = 4
) (
  input  logic i_clk,
  input  logic i_pipeline_reset,
  input  logic i_pipeline_stall,
  output logic o_vld,
  output logic o_pc_vld
);

  // Bit k is set once the pipeline has advanced k+1 times since reset
  logic [NUM_PIPELINE_STAGES-1:0] fill_sr;

  // Each advancing cycle shifts a one in at the bottom, a stall freezes it
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      fill_sr <= '0;
    end else if (!i_pipeline_stall) begin
      fill_sr <= {fill_sr[NUM_PIPELINE_STAGES-2:0], 1'b1};
    end
  end

  // The top bit means a real instruction has reached the last stage
  assign o_vld = fill_sr[NUM_PIPELINE_STAGES-1] && !i_pipeline_stall;

  // The PC is known in ID, which is PC_VALID_STAGE_OFFSET stages before the end
  assign o_pc_vld = fill_sr[NUM_PIPELINE_STAGES-PC_VALID_STAGE_OFFSET] && !i_pipeline_stall;

endmodule : retire_tracker

// File: src/hazard_resolution_unit.sv
// Top level of the hazard and flush controller, forms the pipeline reset and wires the sub-blocks
module hazard_resolution_unit
  import hru_pkg::*;
#(
  parameter int unsigned     NUM_PIPELINE_STAGES   = 6,
  parameter int unsigned     PC_VALID_STAGE_OFFSET = 4,
  parameter logic [XLEN-1:0] MMIO_ADDR             = 32'h4000_0000,
  parameter logic [XLEN-1:0] MMIO_SIZE_BYTES       = 32'h28
) (
  input  logic           i_clk,
  input  logic           i_rst,
  input  pd_to_id_t      i_from_pd_to_id,
  input  id_to_ex_t      i_from_id_to_ex,
  input  ex_comb_t       i_from_ex_comb,
  input  ex_to_ma_t      i_from_ex_to_ma,
  input  cache_status_t  i_from_cache,
  input  logic           i_trap_taken,
  input  logic           i_mret_taken,
  input  logic           i_stall_for_wfi,
  output pipeline_ctrl_t o_pipeline_ctrl,
  output logic           o_mmio_read_pulse,
  output logic           o_rst_done,
  output logic           o_vld,
  output logic           o_pc_vld
);

  logic pipeline_reset;
  logic pipeline_stall;
  logic pipeline_flush;
  logic load_use_stall;
  logic load_use_detected;
  logic mmio_load_stall;
  logic mul_div_stall;
  logic stall_registered;
  logic trap_taken_registered;
  logic mret_taken_registered;

  // The pipeline stays in reset until the cache finishes clearing its tags
  assign pipeline_reset = i_rst || i_from_cache.cache_reset_in_progress;
  assign o_rst_done     = !i_from_cache.cache_reset_in_progress;

  // ====================
  // Stall sources
  // ====================

  load_use_detector u_load_use_detector (
    .i_clk                      (i_clk),
    .i_pipeline_reset           (pipeline_reset),
    .i_pipeline_stall           (pipeline_stall),
    .i_pipeline_flush           (pipeline_flush),
    .i_from_pd_to_id            (i_from_pd_to_id),
    .i_from_id_to_ex            (i_from_id_to_ex),
    .i_from_ex_to_ma            (i_from_ex_to_ma),
    .i_cache_hit_on_load_reg    (i_from_cache.cache_hit_on_load_reg),
    .i_mul_div_stall            (mul_div_stall),
    .o_load_use_hazard_detected (load_use_detected),
    .o_stall_for_load_use_hazard(load_use_stall)
  );

  mmio_read_sequencer #(
    .MMIO_ADDR      (MMIO_ADDR),
    .MMIO_SIZE_BYTES(MMIO_SIZE_BYTES)
  ) u_mmio_read_sequencer (
    .i_clk            (i_clk),
    .i_pipeline_reset (pipeline_reset),
    .i_pipeline_stall (pipeline_stall),
    .i_pipeline_flush (pipeline_flush),
    .i_from_ex_to_ma  (i_from_ex_to_ma),
    .o_mmio_load_stall(mmio_load_stall),
    .o_mmio_read_pulse(o_mmio_read_pulse)
  );

  // ====================
  // Stall and flush
  // ====================

  // Load-use and MMIO stalls come from registers and MA/EX inputs only, so no loop forms here
  stall_arbiter u_stall_arbiter (
    .i_clk            (i_clk),
    .i_pipeline_reset (pipeline_reset),
    .i_from_id_to_ex  (i_from_id_to_ex),
    .i_from_ex_comb   (i_from_ex_comb),
    .i_load_use_stall (load_use_stall),
    .i_mmio_load_stall(mmio_load_stall),
    .i_stall_for_wfi  (i_stall_for_wfi),
    .i_trap_taken     (i_trap_taken),
    .i_mret_taken     (i_mret_taken),
    .o_mul_div_stall  (mul_div_stall),
    .o_pipeline_stall (pipeline_stall)
  );

  flush_controller u_flush_controller (
    .i_clk                  (i_clk),
    .i_pipeline_reset       (pipeline_reset),
    .i_pipeline_stall       (pipeline_stall),
    .i_branch_taken         (i_from_ex_comb.branch_taken),
    .i_trap_taken           (i_trap_taken),
    .i_mret_taken           (i_mret_taken),
    .o_pipeline_flush       (pipeline_flush),
    .o_stall_registered     (stall_registered),
    .o_trap_taken_registered(trap_taken_registered),
    .o_mret_taken_registered(mret_taken_registered)
  );

  retire_tracker #(
    .NUM_PIPELINE_STAGES  (NUM_PIPELINE_STAGES),
    .PC_VALID_STAGE_OFFSET(PC_VALID_STAGE_OFFSET)
  ) u_retire_tracker (
    .i_clk           (i_clk),
    .i_pipeline_reset(pipeline_reset),
    .i_pipeline_stall(pipeline_stall),
    .o_vld           (o_vld),
    .o_pc_vld        (o_pc_vld)
  );

  // All control fields leave through one bundle
  assign o_pipeline_ctrl = '{
    reset:                     pipeline_reset,
    stall:                     pipeline_stall,
    flush:                     pipeline_flush,
    stall_registered:          stall_registered,
    stall_for_load_use_hazard: load_use_stall,
    load_use_hazard_detected:  load_use_detected,
    trap_taken_registered:     trap_taken_registered,
    mret_taken_registered:     mret_taken_registered
  };

endmodule : hazard_resolution_unit

// File: dv/hru_ref_model.svh
// Cycle-level reference model of the hazard unit that the testbench module includes
`ifndef HRU_REF_MODEL_SVH
`define HRU_REF_MODEL_SVH

// Everything the testbench drives into the DUT in one cycle
typedef struct packed {
  logic          rst;
  pd_to_id_t     pd;
  id_to_ex_t     ex;
  ex_comb_t      comb;
  ex_to_ma_t     ma;
  cache_status_t cache;
  logic          trap;
  logic          mret;
  logic          wfi;
} stim_t;

// Outputs the model predicts for the current cycle
typedef struct packed {
  logic reset;
  logic rst_done;
  logic stall;
  logic flush;
  logic stall_reg;
  logic lu_stall;
  logic lu_detected;
  logic trap_reg;
  logic mret_reg;
  logic pulse;
  logic vld;
  logic pc_vld;
} expected_t;

// ====================
// Model state
// ====================

logic m_pot       = 1'b0;
logic m_b2b       = 1'b0;
int   m_phase     = 0;
logic m_mul_done  = 1'b0;
logic m_csr_wait  = 1'b0;
logic m_branch    = 1'b0;
logic m_trap      = 1'b0;
logic m_mret      = 1'b0;
logic m_stall_reg = 1'b0;
int   m_fill      = 0;

// A load in EX whose nonzero destination feeds either source in PD
function automatic logic load_hazard_in_ex(input stim_t s);
  logic match;
  match = (s.ex.dest_reg == s.pd.rs1_early) || (s.ex.dest_reg == s.pd.rs2_early);
  return s.ex.is_load && (s.ex.dest_reg != 5'd0) && match;
endfunction

// Window check done on 33 bits so the upper bound cannot wrap
function automatic logic in_mmio_window(input ex_to_ma_t ma);
  logic [32:0] addr;
  logic [32:0] lo;
  logic [32:0] hi;
  addr = {1'b0, ma.data_addr};
  lo   = {1'b0, MMIO_BASE};
  hi   = {1'b0, MMIO_BASE} + {1'b0, MMIO_BYTES};
  return ma.is_load && (addr >= lo) && (addr < hi);
endfunction

function automatic expected_t predict_outputs(input stim_t s);
  expected_t e;
  logic      mul_div;
  logic      mmio_stall;
  logic      csr_stall;
  logic      sources;
  logic      events;
  mul_div       = (s.ex.is_multiply && !m_mul_done) || (s.ex.is_divide && s.comb.div_busy);
  e.lu_detected = m_pot && !m_b2b && !s.cache.cache_hit_on_load_reg;
  e.lu_stall    = e.lu_detected && !mul_div;
  mmio_stall    = in_mmio_window(s.ma) && (m_phase != 2);
  e.pulse       = in_mmio_window(s.ma) && (m_phase == 0);
  csr_stall     = s.ex.is_csr && !m_csr_wait;
  sources       = mul_div || e.lu_stall || mmio_stall || csr_stall || s.wfi;
  // Trap and MRET win over every stall source
  e.stall       = sources && !s.trap && !s.mret;
  events        = s.comb.branch_taken || m_branch || s.trap || m_trap || s.mret || m_mret;
  e.flush       = events && !e.stall;
  e.stall_reg   = m_stall_reg;
  e.trap_reg    = m_trap;
  e.mret_reg    = m_mret;
  e.reset       = s.rst || s.cache.cache_reset_in_progress;
  e.rst_done    = !s.cache.cache_reset_in_progress;
  e.vld         = (m_fill >= STAGES) && !e.stall;
  e.pc_vld      = (m_fill >= STAGES - PC_OFFSET + 1) && !e.stall;
  return e;
endfunction

// Moves the model across one rising clock edge
function automatic void advance_model(input stim_t s);
  expected_t e;
  e = predict_outputs(s);
  if (s.rst || s.cache.cache_reset_in_progress) begin
    m_pot       = 1'b0;
    m_b2b       = 1'b0;
    m_phase     = 0;
    m_mul_done  = 1'b0;
    m_csr_wait  = 1'b0;
    m_branch    = 1'b0;
    m_trap      = 1'b0;
    m_mret      = 1'b0;
    m_stall_reg = 1'b0;
    m_fill      = 0;
  end else begin
    if (e.flush) begin
      m_pot = 1'b0;
    end else if (!e.stall) begin
      m_pot = load_hazard_in_ex(s);
    end
    // The load that took its bubble must not take another one
    if (e.lu_stall) begin
      m_b2b = 1'b1;
    end else if (!e.stall) begin
      m_b2b = 1'b0;
    end else begin
      m_b2b = m_b2b && s.ma.is_load;
    end
    if (e.flush || !e.stall) begin
      m_phase = 0;
    end else if (in_mmio_window(s.ma)) begin
      m_phase = (m_phase == 0) ? 1 : 2;
    end
    m_mul_done = s.comb.mul_completing_next_cycle;
    m_csr_wait = s.ex.is_csr && !m_csr_wait;
    m_branch   = s.comb.branch_taken && !e.stall;
    m_trap     = s.trap && !e.stall;
    m_mret     = s.mret && !e.stall;
    // The stall history forgets everything on a flush
    m_stall_reg = e.flush ? 1'b0 : e.stall;
    if (!e.stall && (m_fill < STAGES)) begin
      m_fill = m_fill + 1;
    end
  end
endfunction

`endif

// File: dv/tb_hazard_resolution_unit.sv
// Self-checking testbench that runs directed tests and then a random mix against the model
module tb_hazard_resolution_unit
  import hru_pkg::*;
;

  localparam int unsigned STAGES     = 6;
  localparam int unsigned PC_OFFSET  = 4;
  localparam logic [31:0] MMIO_BASE  = 32'h4000_0000;
  localparam logic [31:0] MMIO_BYTES = 32'h28;

  `include "hru_ref_model.svh"

  logic           i_clk = 1'b0;
  stim_t          stim;
  pipeline_ctrl_t o_pipeline_ctrl;
  logic           o_mmio_read_pulse;
  logic           o_rst_done;
  logic           o_vld;
  logic           o_pc_vld;

  logic [31:0] seed = 32'd13873;
  int          errors = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          stall_seen = 0;
  int          flush_seen = 0;
  int          pulse_seen = 0;
  logic        timed_out = 1'b0;

  hazard_resolution_unit #(
    .NUM_PIPELINE_STAGES  (STAGES),
    .PC_VALID_STAGE_OFFSET(PC_OFFSET),
    .MMIO_ADDR            (MMIO_BASE),
    .MMIO_SIZE_BYTES      (MMIO_BYTES)
  ) dut0 (
    .i_clk            (i_clk),
    .i_rst            (stim.rst),
    .i_from_pd_to_id  (stim.pd),
    .i_from_id_to_ex  (stim.ex),
    .i_from_ex_comb   (stim.comb),
    .i_from_ex_to_ma  (stim.ma),
    .i_from_cache     (stim.cache),
    .i_trap_taken     (stim.trap),
    .i_mret_taken     (stim.mret),
    .i_stall_for_wfi  (stim.wfi),
    .o_pipeline_ctrl  (o_pipeline_ctrl),
    .o_mmio_read_pulse(o_mmio_read_pulse),
    .o_rst_done       (o_rst_done),
    .o_vld            (o_vld),
    .o_pc_vld         (o_pc_vld)
  );

  initial begin
    forever #50 i_clk = ~i_clk;
  end

  // ====================
  // Compare process
  // ====================

  // Inputs change just after the rising edge, so the falling edge sees settled outputs
  always @(negedge i_clk) begin
    expected_t exp_v;
    expected_t got;
    exp_v           = predict_outputs(stim);
    got.reset       = o_pipeline_ctrl.reset;
    got.rst_done    = o_rst_done;
    got.stall       = o_pipeline_ctrl.stall;
    got.flush       = o_pipeline_ctrl.flush;
    got.stall_reg   = o_pipeline_ctrl.stall_registered;
    got.lu_stall    = o_pipeline_ctrl.stall_for_load_use_hazard;
    got.lu_detected = o_pipeline_ctrl.load_use_hazard_detected;
    got.trap_reg    = o_pipeline_ctrl.trap_taken_registered;
    got.mret_reg    = o_pipeline_ctrl.mret_taken_registered;
    got.pulse       = o_mmio_read_pulse;
    got.vld         = o_vld;
    got.pc_vld      = o_pc_vld;
    assert (got == exp_v) else begin
      $display("FAIL at %0t: outputs %b, expected %b", $time, got, exp_v);
      errors = errors + 1;
    end
    stall_seen = stall_seen + int'(got.stall);
    flush_seen = flush_seen + int'(got.flush);
    pulse_seen = pulse_seen + int'(got.pulse);
    advance_model(stim);
  end

  // ====================
  // Helpers
  // ====================

  // Returns the upper half of the LCG state because the low bits cycle too quickly
  function automatic logic [15:0] lcg_bits();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[31:16];
  endfunction

  task automatic step(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #5;
    end
  endtask

  task automatic clear_inputs();
    stim.pd   = '0;
    stim.ex   = '0;
    stim.comb = '0;
    stim.ma   = '0;
    stim.trap = 1'b0;
    stim.mret = 1'b0;
    stim.wfi  = 1'b0;
    stim.cache.cache_hit_on_load_reg = 1'b0;
  endtask

  task automatic zero_counters();
    stall_seen = 0;
    flush_seen = 0;
    pulse_seen = 0;
  endtask

  task automatic drain_stall(input int limit);
    int waited;
    waited = 0;
    while (!timed_out && o_pipeline_ctrl.stall && waited < limit) begin
      step(1);
      waited = waited + 1;
    end
    if (!timed_out && o_pipeline_ctrl.stall) begin
      $display("Timeout: stall still high after %0d cycles at %0t", limit, $time);
      timed_out = 1'b1;
    end
  endtask

  task automatic await_vld(input int limit);
    int waited;
    waited = 0;
    while (!timed_out && !o_vld && waited < limit) begin
      step(1);
      waited = waited + 1;
    end
    if (!timed_out && !o_vld) begin
      $display("Timeout: o_vld did not rise within %0d cycles", limit);
      timed_out = 1'b1;
    end
  endtask

  // Lets any stall drain, then idles two cycles so no flush leaks into the next case
  task automatic settle();
    clear_inputs();
    step(1);
    drain_stall(20);
    step(2);
  endtask

  task automatic check_count(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("FAIL at %0t: %s counted %0d, expected %0d", $time, what, got, want);
      errors = errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before && !timed_out) begin
      tests_ok = tests_ok + 1;
      $display("Test %s: ok", name);
    end else begin
      tests_bad = tests_bad + 1;
      $display("Test %s: %0d mismatches", name, errors - errors_before);
    end
  endtask

  // ====================
  // Directed tests
  // ====================

  task automatic reset_and_fill();
    int e0;
    e0 = errors;
    step(16);
    stim.rst = 1'b0;
    // The cache keeps the pipeline in reset a little longer
    step(4);
    stim.cache.cache_reset_in_progress = 1'b0;
    await_vld(20);
    step(2);
    finish_test("reset", e0);
  endtask

  task automatic load_use_cases();
    int e0;
    e0 = errors;
    zero_counters();
    stim.ex.is_load = 1'b1;
    stim.ex.dest_reg = 5'd5;
    stim.pd.rs1_early = 5'd5;
    step(1);
    settle();
    check_count("load-use miss stalls", stall_seen, 1);
    zero_counters();
    stim.ex.is_load = 1'b1;
    stim.ex.dest_reg = 5'd7;
    stim.pd.rs2_early = 5'd7;
    step(1);
    clear_inputs();
    // The hit flag must be high in the cycle that would otherwise stall
    stim.cache.cache_hit_on_load_reg = 1'b1;
    step(1);
    settle();
    check_count("load-use hit stalls", stall_seen, 0);
    zero_counters();
    stim.ex.is_load = 1'b1;
    stim.ex.dest_reg = 5'd0;
    stim.pd.rs1_early = 5'd0;
    step(1);
    settle();
    check_count("x0 load stalls", stall_seen, 0);
    finish_test("load_use", e0);
  endtask

  task automatic mul_div_csr_cases();
    int e0;
    e0 = errors;
    zero_counters();
    stim.ex.is_multiply = 1'b1;
    step(3);
    stim.comb.mul_completing_next_cycle = 1'b1;
    step(1);
    stim.comb.mul_completing_next_cycle = 1'b0;
    drain_stall(10);
    settle();
    check_count("multiply stalls", stall_seen, 4);
    zero_counters();
    stim.ex.is_divide = 1'b1;
    stim.comb.div_busy = 1'b1;
    step(5);
    stim.comb.div_busy = 1'b0;
    settle();
    check_count("divide stalls", stall_seen, 5);
    zero_counters();
    stim.ex.is_csr = 1'b1;
    step(2);
    settle();
    check_count("CSR stalls", stall_seen, 1);
    finish_test("mul_div_csr", e0);
  endtask

  task automatic mmio_window_cases();
    int e0;
    e0 = errors;
    zero_counters();
    stim.ma.is_load = 1'b1;
    stim.ma.data_addr = MMIO_BASE + 32'd4;
    step(3);
    settle();
    check_count("MMIO stalls", stall_seen, 2);
    check_count("MMIO pulses", pulse_seen, 1);
    zero_counters();
    stim.ma.is_load = 1'b1;
    stim.ma.data_addr = MMIO_BASE - 32'd4;
    step(2);
    stim.ma.data_addr = MMIO_BASE + MMIO_BYTES;
    step(2);
    settle();
    check_count("outside window stalls", stall_seen, 0);
    check_count("outside window pulses", pulse_seen, 0);
    finish_test("mmio", e0);
  endtask

  task automatic flush_and_override();
    int e0;
    e0 = errors;
    zero_counters();
    stim.comb.branch_taken = 1'b1;
    step(1);
    settle();
    stim.trap = 1'b1;
    step(1);
    settle();
    stim.mret = 1'b1;
    step(1);
    settle();
    check_count("event flushes", flush_seen, 6);
    // A trap arriving during WFI releases the stall for its own cycle
    zero_counters();
    stim.wfi = 1'b1;
    step(1);
    stim.trap = 1'b1;
    step(1);
    stim.trap = 1'b0;
    step(1);
    settle();
    check_count("WFI stalls around trap", stall_seen, 2);
    check_count("trap flush cut by stall", flush_seen, 1);
    zero_counters();
    stim.comb.branch_taken = 1'b1;
    step(1);
    stim.comb.branch_taken = 1'b0;
    stim.wfi = 1'b1;
    step(1);
    settle();
    check_count("branch flush cut by stall", flush_seen, 1);
    finish_test("flush", e0);
  endtask

  task automatic random_mix();
    int          e0;
    logic [15:0] r0;
    logic [15:0] r1;
    logic [15:0] r2;
    e0 = errors;
    repeat (2000) begin
      r0 = lcg_bits();
      r1 = lcg_bits();
      r2 = lcg_bits();
      // Narrow register indices so that dependencies happen often
      stim.pd.rs1_early = {2'b00, r0[2:0]};
      stim.pd.rs2_early = {2'b00, r0[5:3]};
      stim.ex.is_load = r0[6];
      stim.ex.dest_reg = {2'b00, r0[9:7]};
      stim.ex.is_multiply = (r0[12:10] == 3'd0);
      stim.ex.is_divide = (r0[15:13] == 3'd0);
      stim.ex.is_csr = (r1[2:0] == 3'd0);
      stim.comb.branch_taken = (r1[5:3] == 3'd0);
      stim.comb.mul_completing_next_cycle = r1[6];
      stim.comb.div_busy = (r1[8:7] != 2'd0);
      stim.ma.is_load = r1[9];
      // Addresses straddle both edges of the MMIO window
      stim.ma.data_addr = MMIO_BASE - 32'd8 + {25'd0, r1[14:10], 2'b00};
      stim.cache.cache_hit_on_load_reg = r1[15];
      stim.trap = (r2[3:0] == 4'd0);
      stim.mret = (r2[7:4] == 4'd0);
      stim.wfi = (r2[11:8] == 4'd0);
      step(1);
    end
    settle();
    finish_test("random", e0);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    stim = '0;
    stim.rst = 1'b1;
    stim.cache.cache_reset_in_progress = 1'b1;
    reset_and_fill();
    if (!timed_out) load_use_cases();
    if (!timed_out) mul_div_csr_cases();
    if (!timed_out) mmio_window_cases();
    if (!timed_out) flush_and_override();
    if (!timed_out) random_mix();
    $display("Tests: %0d ok, %0d failed, %0d mismatches", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_hazard_resolution_unit

// File: filelist.f
+incdir+dv
src/hru_pkg.sv
src/load_use_detector.sv
src/mmio_read_sequencer.sv
src/stall_arbiter.sv
src/flush_controller.sv
src/retire_tracker.sv
src/hazard_resolution_unit.sv
dv/tb_hazard_resolution_unit.sv

// File: run_sim.sh
#!/bin/sh
# Builds with Verilator, runs the simulation and checks the log
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal --top-module tb_hazard_resolution_unit \
  -f filelist.f -o sim_hru && ./obj_dir/sim_hru > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Testbench passed" sim.log && echo "Simulation OK" || { echo "Simulation FAILED"; exit 1; }
